//--- sim.f
+incdir+design
design/minion_pkg.sv
design/bus_decode.sv
design/periph_regs.sv
design/uart_core.sv
design/rx_fifo.sv
design/minion_periph.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- Bender.yml
package:
  name: minion_periph

sources:
  - include_dirs:
      - design
    files:
      - design/minion_pkg.sv
      - design/bus_decode.sv
      - design/periph_regs.sv
      - design/uart_core.sv
      - design/rx_fifo.sv
      - design/minion_periph.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_clkgen.sv
      - verif/tb_checker.sv
      - verif/tb_top.sv

//--- verif/tb_top.sv
/*
 * testbench top: clock, DUT, checker, random stimulus, watchdog
 */
`timescale 1ns/1ns
`default_nettype none

module tb_top;

  localparam int    N_FRAMES   = 25;
  localparam longint TIMEOUT_NS = N_FRAMES * 10 * 16 * 20 + N_FRAMES * 4 * 16 * 20 + 50_000;

  wire         msoc_clk;
  wire         rstn;
  wire [31:0]  rdata;
  wire         serial_tx;
  wire [7:0]   led;
  logic        ce;
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic        serial_rx;
  logic [15:0] dip;
  int          baud;

  tb_clkgen i_clkgen (.msoc_clk(msoc_clk), .rstn(rstn));

  minion_periph i_dut (
    .msoc_clk(msoc_clk), .rstn(rstn), .ce_i(ce), .we_i(we), .addr_i(addr),
    .wdata_i(wdata), .rdata_o(rdata), .serial_rx_i(serial_rx),
    .serial_tx_o(serial_tx), .led_o(led), .dip_i(dip)
  );

  tb_checker i_chk (
    .msoc_clk(msoc_clk), .rstn(rstn), .ce_i(ce), .we_i(we), .addr_i(addr),
    .wdata_i(wdata), .rdata_i(rdata), .dip_i(dip), .serial_rx_i(serial_rx),
    .serial_tx_i(serial_tx), .led_i(led)
  );

  task automatic bus_write(input int region, input int offset, input logic [31:0] data);
    @(negedge msoc_clk);
    ce    = 1'b1;
    we    = 1'b1;
    addr  = (region << 20) | (offset << 2);
    wdata = data;
    @(negedge msoc_clk);
    ce = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(input int region);
    @(negedge msoc_clk);
    ce   = 1'b1;
    we   = 1'b0;
    addr = (region << 20) | ($urandom_range(0, 15) << 2);
    dip  = $urandom();  // fresh pins, read must show last cycle's value
    @(negedge msoc_clk);
    ce = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] data, input logic stop);
    logic [9:0] bits;
    bits = {stop, data, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      @(negedge msoc_clk);
      serial_rx = bits[i];
      repeat (baud) @(negedge msoc_clk);  // baud+1 cycles per bit
    end
    @(negedge msoc_clk);
    serial_rx = 1'b1;
    repeat (2 * (baud + 1)) @(negedge msoc_clk);  // idle gap
  endtask

  task automatic wait_tx_done(input int start);
    int k;
    k = 0;
    while (i_chk.tx_done == start && k < 12 * 16 + 20)
    begin
      @(negedge msoc_clk);
      k++;
    end
    if (i_chk.tx_done == start)
      i_chk.note("transmit frame did not finish in time");
  endtask

  task automatic drain_fifo(input int pops);
    for (int i = 0; i < pops; i++)
    begin
      bus_read(3);
      bus_write(3, 0, $urandom());
    end
    bus_read(3);
  endtask

  initial
  begin
    int r;
    int start;
    ce        = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    serial_rx = 1'b1;
    dip       = '0;
    void'($urandom(32'h75ed_bad7));
    wait (rstn === 1'b1);

    bus_read(3);
    bus_read(7);
    i_chk.end_test("reset state");

    for (int i = 0; i < 8; i++)
    begin
      bus_write(7, 0, $urandom());
      bus_read(7);
      do
        r = $urandom_range(0, 15);
      while (r == 3 || r == 7);
      bus_read(r);
    end
    i_chk.end_test("leds and dip switches");

    baud = $urandom_range(4, 15);
    bus_write(2, 1, baud);
    for (int i = 0; i < 3; i++)
    begin
      start = i_chk.tx_done;
      bus_write(2, 0, $urandom());
      repeat (3) @(negedge msoc_clk);
      bus_write(2, 0, $urandom());  // busy, must not disturb the frame
      wait_tx_done(start);
    end
    i_chk.end_test("transmit");

    for (int i = 0; i < 5; i++)
    begin
      send_frame($urandom(), i != 2);
      bus_write(7, 0, $urandom());
    end
    drain_fifo(5);
    i_chk.end_test("receive order");

    for (int i = 0; i < 17; i++)
      send_frame($urandom(), 1'b1);
    drain_fifo(17);
    i_chk.end_test("fifo edges");

    i_chk.summary();
    if (i_chk.errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog: run exceeded %0d ns", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

endmodule
`default_nettype wire

//--- verif/tb_checker.sv
/*
 * reference model and scoreboard for the minion peripherals
 * tracks leds, dip sync, baud divisor, rx fifo contents and flags,
 * decodes both serial lines at mid-bit and compares bus reads
 */
`timescale 1ns/1ns
`default_nettype none
`include "minion_settings.svh"

module tb_checker (
  input wire        msoc_clk,
  input wire        rstn,
  input wire        ce_i,
  input wire        we_i,
  input wire [31:0] addr_i,
  input wire [31:0] wdata_i,
  input wire [31:0] rdata_i,
  input wire [15:0] dip_i,
  input wire        serial_rx_i,
  input wire        serial_tx_i,
  input wire [7:0]  led_i
);

  logic [7:0]  led_m;
  logic [15:0] dip_m;
  logic [15:0] baud_m;
  logic [8:0]  rxq[$];  // {frame_err, byte}
  logic [7:0]  txq[$];
  bit          rd_err_m;
  bit          wr_err_m;
  bit          tx_busy;
  bit          rx_busy;
  int          tx_done;
  int          errors;
  int          err_mark;
  int          tests_ok;
  int          tests_bad;

  wire [3:0] region = addr_i[23:20];
  wire [3:0] offset = addr_i[5:2];
  wire       wr     = ce_i & we_i;
  wire       rd     = ce_i & !we_i;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic note(input string msg);
    $display("%0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input string name);
    if (errors > err_mark)
    begin
      tests_bad++;
      $display("test %s: FAIL, %0d errors", name, errors - err_mark);
    end
    else
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    err_mark = errors;
  endtask

  task automatic summary();
    $display("tests: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, errors);
  endtask

  // expected status word, head fields only meaningful when not empty
  function automatic logic [31:0] status_exp();
    logic [8:0] head;
    int         n;
    n    = rxq.size();
    head = (n != 0) ? rxq[0] : 9'h0;
    return {4'h0, 12'(n), n >= `MINION_RXFIFO_DEPTH - 2, n == `MINION_RXFIFO_DEPTH,
            rd_err_m, wr_err_m, head[8], tx_busy, rx_busy, n != 0, head[7:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // bus side model and read compare

  always @(posedge msoc_clk or negedge rstn)
  begin
    logic [31:0] exp;
    logic [31:0] mask;
    if (!rstn)
    begin
      led_m    <= '0;
      baud_m   <= 16'd87;
      rd_err_m = 0;
      wr_err_m = 0;
      tx_busy  = 0;
      rxq.delete();
      txq.delete();
    end
    else
    begin
      mask = '1;
      if (rd)
      begin
        if (region == 4'd3)
        begin
          exp = status_exp();
          if (rxq.size() == 0)
            mask = 32'hffff_f700;  // head entry is stale when empty
        end
        else if (region == 4'd7)
          exp = {16'h0, dip_m};
        else
          exp = '0;
        check("rdata_o", exp & mask, rdata_i & mask);
      end
      dip_m <= dip_i;
      if (wr && region == 4'd7)
        led_m <= wdata_i[7:0];
      if (wr && region == 4'd2 && offset == 4'd1)
        baud_m <= wdata_i[15:0];
      if (wr && region == 4'd2 && offset == 4'd0 && !tx_busy)
      begin
        txq.push_back(wdata_i[7:0]);
        tx_busy = 1;  // later writes are dropped until the frame ends
      end
      if (wr && region == 4'd3)
      begin
        if (rxq.size() == 0)
          rd_err_m = 1;
        else
          void'(rxq.pop_front());
      end
    end
  end

  always @(negedge msoc_clk)
  begin
    if (rstn)
      check("led_o", {24'h0, led_m}, {24'h0, led_i});
  end

  initial
  begin
    @(posedge rstn);
    @(posedge msoc_clk);
    check("serial_tx_o", 32'h1, {31'h0, serial_tx_i});  // idle line after reset
  end

  ////////////////////////////////////////////////////////////
  // transmit line decoder

  initial
  begin
    logic [7:0] got;
    int         k;
    forever
    begin
      @(posedge msoc_clk);
      if (txq.size() != 0)
      begin
        k = 0;
        while (serial_tx_i !== 1'b0 && k < 4)
        begin
          @(posedge msoc_clk);
          k++;
        end
        if (serial_tx_i !== 1'b0)
          note($sformatf("transmit frame for byte %h never started", txq[0]));
        else
        begin
          repeat ((baud_m + 1) / 2) @(posedge msoc_clk);  // middle of start bit
          check("serial_tx_o start", 32'h0, {31'h0, serial_tx_i});
          for (int i = 0; i < 8; i++)
          begin
            repeat (baud_m + 1) @(posedge msoc_clk);
            got[i] = serial_tx_i;
          end
          check("serial_tx_o data", {24'h0, txq[0]}, {24'h0, got});
          repeat (baud_m + 1) @(posedge msoc_clk);
          check("serial_tx_o stop", 32'h1, {31'h0, serial_tx_i});
          repeat ((baud_m + 1) / 2 + 1) @(posedge msoc_clk);  // rest of stop bit
        end
        void'(txq.pop_front());
        tx_busy = 0;
        tx_done++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // receive line decoder, feeds the fifo model

  initial
  begin
    logic [7:0] data;
    logic       stop;
    forever
    begin
      @(posedge msoc_clk);
      if (rstn && serial_rx_i === 1'b0)
      begin
        rx_busy = 1;
        repeat ((baud_m + 1) / 2) @(posedge msoc_clk);
        for (int i = 0; i < 8; i++)
        begin
          repeat (baud_m + 1) @(posedge msoc_clk);
          data[i] = serial_rx_i;  // lsb first
        end
        repeat (baud_m + 1) @(posedge msoc_clk);
        stop = serial_rx_i;
        if (rxq.size() == `MINION_RXFIFO_DEPTH)
          wr_err_m = 1;  // overflow drops the byte
        else
          rxq.push_back({!stop, data});
        rx_busy = 0;
        while (serial_rx_i === 1'b0)
          @(posedge msoc_clk);  // low stop bit is not a new start
      end
    end
  end

endmodule
`default_nettype wire

//--- verif/tb_clkgen.sv
/*
 * testbench clock and reset source
 * 20 ns clock, reset held low for five cycles
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic msoc_clk,
  output logic rstn
);

  initial
  begin
    msoc_clk = 1'b0;
    forever #10 msoc_clk = ~msoc_clk;  // 50 MHz
  end

  initial
  begin
    rstn = 1'b0;
    repeat (5) @(posedge msoc_clk);
    @(negedge msoc_clk);
    rstn = 1'b1;  // released away from the active edge
  end

endmodule
`default_nettype wire

//--- design/minion_periph.sv
/*
 * peripheral side of the minion soc
 * address decoder, register block, 8N1 uart and receive fifo
 */
`timescale 1ns/1ns
`default_nettype none
`include "minion_settings.svh"

module minion_periph (
  input  wire                         msoc_clk,
  input  wire                         rstn,
  input  wire                         ce_i,
  input  wire                         we_i,
  input  wire [`MINION_DATA_W-1:0]    addr_i,
  input  wire [`MINION_DATA_W-1:0]    wdata_i,
  output wire [`MINION_DATA_W-1:0]    rdata_o,
  input  wire                         serial_rx_i,
  output wire                         serial_tx_o,
  output wire [`MINION_LED_W-1:0]     led_o,
  input  wire [`MINION_DIP_W-1:0]     dip_i
);
  import minion_pkg::*;

  wire [`MINION_NUM_REGIONS-1:0]  sel;
  wire                            wr_stb;
  wire uart_status_u              rd_uart;
  wire [`MINION_DATA_W-1:0]       rd_board;
  wire                            tx_start;
  wire [7:0]                      tx_byte;
  wire [`MINION_BAUD_W-1:0]       baud_div;
  wire                            transmitting;
  wire                            receiving;
  wire                            rx_valid;
  wire [7:0]                      rx_byte;
  wire                            rx_frame_err;
  wire [8:0]                      fifo_head;  // {frame_err, byte}
  wire [`MINION_RXFIFO_CNT_W-1:0] fifo_count;
  wire                            fifo_full;
  wire                            fifo_almost_full;
  wire                            fifo_empty;
  wire                            fifo_rd_err;
  wire                            fifo_wr_err;

  bus_decode i_bus_decode (
    .ce_i       (ce_i),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .rd_uart_i  (rd_uart),
    .rd_board_i (rd_board),
    .sel_o      (sel),
    .wr_stb_o   (wr_stb),
    .rdata_o    (rdata_o)
  );

  periph_regs i_periph_regs (
    .msoc_clk           (msoc_clk),
    .rstn               (rstn),
    .sel_i              (sel),
    .wr_stb_i           (wr_stb),
    .addr_i             (addr_i),
    .wdata_i            (wdata_i),
    .dip_i              (dip_i),
    .transmitting_i     (transmitting),
    .receiving_i        (receiving),
    .fifo_byte_i        (fifo_head[7:0]),
    .fifo_frame_err_i   (fifo_head[8]),
    .fifo_count_i       (fifo_count),
    .fifo_full_i        (fifo_full),
    .fifo_almost_full_i (fifo_almost_full),
    .fifo_empty_i       (fifo_empty),
    .fifo_rd_err_i      (fifo_rd_err),
    .fifo_wr_err_i      (fifo_wr_err),
    .led_o              (led_o),
    .tx_start_o         (tx_start),
    .tx_byte_o          (tx_byte),
    .baud_div_o         (baud_div),
    .rd_uart_o          (rd_uart),
    .rd_board_o         (rd_board)
  );

  uart_core i_uart_core (
    .msoc_clk       (msoc_clk),
    .rstn           (rstn),
    .baud_div_i     (baud_div),
    .tx_start_i     (tx_start),
    .tx_byte_i      (tx_byte),
    .serial_rx_i    (serial_rx_i),
    .serial_tx_o    (serial_tx_o),
    .transmitting_o (transmitting),
    .receiving_o    (receiving),
    .rx_valid_o     (rx_valid),
    .rx_byte_o      (rx_byte),
    .rx_frame_err_o (rx_frame_err)
  );

  rx_fifo i_rx_fifo (
    .msoc_clk      (msoc_clk),
    .rstn          (rstn),
    .sel_i         (sel),
    .wr_stb_i      (wr_stb),
    .push_i        (rx_valid),
    .din_i         ({rx_frame_err, rx_byte}),
    .dout_o        (fifo_head),
    .count_o       (fifo_count),
    .full_o        (fifo_full),
    .almost_full_o (fifo_almost_full),
    .empty_o       (fifo_empty),
    .rd_err_o      (fifo_rd_err),
    .wr_err_o      (fifo_wr_err)
  );

endmodule
`default_nettype wire

//--- design/rx_fifo.sv
/*
 * single-clock receive fifo, entries are {frame_err, byte}
 * pop on a write to region 3, sticky over/underflow flags
 */
`timescale 1ns/1ns
`default_nettype none
`include "minion_settings.svh"

module rx_fifo (
  input  wire                              msoc_clk,
  input  wire                              rstn,
  input  wire [`MINION_NUM_REGIONS-1:0]    sel_i,
  input  wire                              wr_stb_i,
  input  wire                              push_i,
  input  wire [8:0]                        din_i,
  output logic [8:0]                       dout_o,
  output logic [`MINION_RXFIFO_CNT_W-1:0]  count_o,
  output logic                             full_o,
  output logic                             almost_full_o,
  output logic                             empty_o,
  output logic                             rd_err_o,
  output logic                             wr_err_o
);

  localparam int DEPTH = `MINION_RXFIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic [8:0]       mem [DEPTH];
  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [PTR_W:0]   count;
  logic             pop;
  logic             do_push;
  logic             do_pop;

  assign pop     = wr_stb_i & sel_i[`MINION_REGION_UART_RX];
  assign do_push = push_i & !full_o;  // overflow drops the byte
  assign do_pop  = pop & !empty_o;

  assign full_o        = count == (PTR_W+1)'(DEPTH);
  assign almost_full_o = count >= (PTR_W+1)'(DEPTH - 2);
  assign empty_o       = count == '0;
  assign count_o       = `MINION_RXFIFO_CNT_W'(count);
  assign dout_o        = mem[rptr];  // head entry

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wptr     <= '0;
      rptr     <= '0;
      count    <= '0;
      rd_err_o <= 1'b0;
      wr_err_o <= 1'b0;
    end
    else
    begin
      if (do_push)
        wptr <= wptr + 1'b1;
      if (do_pop)
        rptr <= rptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (push_i && full_o)
        wr_err_o <= 1'b1;  // held until reset
      if (pop && empty_o)
        rd_err_o <= 1'b1;
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (do_push)
      mem[wptr] <= din_i;
  end

  a_count_bound : assert property (@(posedge msoc_clk) disable iff (!rstn)
    count <= (PTR_W+1)'(DEPTH))
    else $error("rx fifo count %0d above depth", count);

endmodule
`default_nettype wire

//--- design/uart_core.sv
/*
 * 8N1 uart, lsb first, bit time is baud_div+1 cycles
 * transmitter shift register, receiver with 3-sample majority filter
 */
`timescale 1ns/1ns
`default_nettype none
`include "minion_settings.svh"

module uart_core (
  input  wire                        msoc_clk,
  input  wire                        rstn,
  input  wire [`MINION_BAUD_W-1:0]   baud_div_i,
  input  wire                        tx_start_i,
  input  wire [7:0]                  tx_byte_i,
  input  wire                        serial_rx_i,
  output logic                       serial_tx_o,
  output logic                       transmitting_o,
  output logic                       receiving_o,
  output logic                       rx_valid_o,
  output logic [7:0]                 rx_byte_o,
  output logic                       rx_frame_err_o
);

  logic [9:0]                tx_shift;  // {stop, data, start}
  logic [`MINION_BAUD_W-1:0] tx_cnt;
  logic [3:0]                tx_bit;
  logic [2:0]                rx_samp;
  logic                      rx_maj;
  logic                      rx_maj_q;
  logic [`MINION_BAUD_W-1:0] rx_cnt;
  logic [3:0]                rx_bit;
  logic                      rx_tick;

  ////////////////////////////////////////////////////////////
  // transmitter

  assign serial_tx_o = tx_shift[0];  // idle shifts in ones

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      tx_shift       <= '1;
      tx_cnt         <= '0;
      tx_bit         <= '0;
      transmitting_o <= 1'b0;
    end
    else if (!transmitting_o)
    begin
      if (tx_start_i)  // starts are ignored while busy
      begin
        tx_shift       <= {1'b1, tx_byte_i, 1'b0};
        tx_cnt         <= '0;
        tx_bit         <= '0;
        transmitting_o <= 1'b1;
      end
    end
    else if (tx_cnt >= baud_div_i)  // end of bit
    begin
      tx_cnt   <= '0;
      tx_shift <= {1'b1, tx_shift[9:1]};
      tx_bit   <= tx_bit + 4'd1;
      if (tx_bit == 4'd9)
        transmitting_o <= 1'b0;  // stop bit done
    end
    else
      tx_cnt <= tx_cnt + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // receiver

  // two of the last three samples win, two cycles of delay
  assign rx_maj  = (rx_samp[0] & rx_samp[1]) | (rx_samp[0] & rx_samp[2]) |
                   (rx_samp[1] & rx_samp[2]);
  assign rx_tick = receiving_o && rx_cnt == '0;  // mid-bit sample point

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rx_samp     <= '1;
      rx_maj_q    <= 1'b1;
      rx_cnt      <= '0;
      rx_bit      <= '0;
      receiving_o <= 1'b0;
      rx_valid_o  <= 1'b0;
    end
    else
    begin
      rx_samp    <= {rx_samp[1:0], serial_rx_i};
      rx_maj_q   <= rx_maj;
      rx_valid_o <= 1'b0;
      if (!receiving_o)
      begin
        if (rx_maj_q && !rx_maj)  // falling edge, start bit
        begin
          receiving_o <= 1'b1;
          rx_cnt      <= baud_div_i >> 1;  // half a bit to the middle
          rx_bit      <= '0;
        end
      end
      else if (!rx_tick)
        rx_cnt <= rx_cnt - 1'b1;
      else
      begin
        rx_cnt <= baud_div_i;
        rx_bit <= rx_bit + 4'd1;
        if (rx_bit == 4'd0 && rx_maj)
          receiving_o <= 1'b0;  // glitch, not a start bit
        else if (rx_bit == 4'd9)
        begin
          receiving_o <= 1'b0;
          rx_valid_o  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (rx_tick && rx_bit >= 4'd1 && rx_bit <= 4'd8)
      rx_byte_o <= {rx_maj, rx_byte_o[7:1]};  // lsb arrives first
    if (rx_tick && rx_bit == 4'd9)
      rx_frame_err_o <= !rx_maj;  // stop bit sampled low
  end

  a_rx_valid_pulse : assert property (@(posedge msoc_clk) disable iff (!rstn)
    rx_valid_o |=> !rx_valid_o)
    else $error("rx_valid longer than one cycle");

endmodule
`default_nettype wire

//--- design/periph_regs.sv
/*
 * register block for regions 2, 3 and 7
 * leds, dip sync, uart tx strobe/byte, baud divisor, status word
 */
`timescale 1ns/1ns
`default_nettype none
`include "minion_settings.svh"

module periph_regs (
  input  wire                              msoc_clk,
  input  wire                              rstn,
  input  wire [`MINION_NUM_REGIONS-1:0]    sel_i,
  input  wire                              wr_stb_i,
  input  wire [`MINION_DATA_W-1:0]         addr_i,
  input  wire [`MINION_DATA_W-1:0]         wdata_i,
  input  wire [`MINION_DIP_W-1:0]          dip_i,
  input  wire                              transmitting_i,
  input  wire                              receiving_i,
  input  wire [7:0]                        fifo_byte_i,
  input  wire                              fifo_frame_err_i,
  input  wire [`MINION_RXFIFO_CNT_W-1:0]   fifo_count_i,
  input  wire                              fifo_full_i,
  input  wire                              fifo_almost_full_i,
  input  wire                              fifo_empty_i,
  input  wire                              fifo_rd_err_i,
  input  wire                              fifo_wr_err_i,
  output logic [`MINION_LED_W-1:0]         led_o,
  output logic                             tx_start_o,
  output logic [7:0]                       tx_byte_o,
  output logic [`MINION_BAUD_W-1:0]        baud_div_o,
  output minion_pkg::uart_status_u         rd_uart_o,
  output logic [`MINION_DATA_W-1:0]        rd_board_o
);
  import minion_pkg::*;

  logic [3:0]               offset;
  logic                     ctrl_wr;
  logic                     tx_wr;
  logic                     baud_wr;
  logic                     board_wr;
  logic [`MINION_DIP_W-1:0] dip_q;
  uart_status_u             status;

  assign offset   = addr_i[5:2];  // word offset inside region 2
  assign ctrl_wr  = wr_stb_i & sel_i[`MINION_REGION_UART_CTRL];
  assign tx_wr    = ctrl_wr && offset == 4'd0 && !tx_start_o;  // one pulse per burst
  assign baud_wr  = ctrl_wr && offset == 4'd1;
  assign board_wr = wr_stb_i & sel_i[`MINION_REGION_BOARD];

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      led_o      <= '0;
      tx_start_o <= 1'b0;
      baud_div_o <= `MINION_BAUD_W'(`MINION_BAUD_DEFAULT);
    end
    else
    begin
      tx_start_o <= tx_wr;
      if (board_wr)
        led_o <= wdata_i[`MINION_LED_W-1:0];
      if (baud_wr)
        baud_div_o <= wdata_i[`MINION_BAUD_W-1:0];
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    dip_q <= dip_i;  // one stage, read lags pin by a cycle
    if (tx_wr)
      tx_byte_o <= wdata_i[7:0];
  end

  ////////////////////////////////////////////////////////////
  // read words

  always_comb
  begin
    status                       = '0;
    status.fields.avail          = fifo_count_i;
    status.fields.almost_full    = fifo_almost_full_i;
    status.fields.full           = fifo_full_i;
    status.fields.rd_err         = fifo_rd_err_i;
    status.fields.wr_err         = fifo_wr_err_i;
    status.fields.head_frame_err = fifo_frame_err_i;
    status.fields.transmitting   = transmitting_i;
    status.fields.receiving      = receiving_i;
    status.fields.not_empty      = !fifo_empty_i;
    status.fields.head_byte      = fifo_byte_i;
  end

  assign rd_uart_o  = status;
  assign rd_board_o = `MINION_DATA_W'(dip_q);

endmodule
`default_nettype wire

//--- design/bus_decode.sv
/*
 * region decoder, one 1 MiB region per value of addr[23:20]
 * one-hot select, write strobe, read data mux
 */
`timescale 1ns/1ns
`default_nettype none
`include "minion_settings.svh"

module bus_decode (
  input  wire                                ce_i,
  input  wire                                we_i,
  input  wire [`MINION_DATA_W-1:0]           addr_i,
  input  wire minion_pkg::uart_status_u      rd_uart_i,
  input  wire [`MINION_DATA_W-1:0]           rd_board_i,
  output logic [`MINION_NUM_REGIONS-1:0]     sel_o,
  output logic                               wr_stb_o,
  output logic [`MINION_DATA_W-1:0]          rdata_o
);
  import minion_pkg::*;

  region_t region;

  assign region   = addr_i[23:20];
  assign wr_stb_o = ce_i & we_i;  // write lands on this edge

  always_comb
  begin
    for (int i = 0; i < `MINION_NUM_REGIONS; i++)
      sel_o[i] = (region == region_t'(i));
  end

  // unmapped and write-only regions read as zero
  always_comb
  begin
    rdata_o = '0;
    if (sel_o[`MINION_REGION_UART_RX])
      rdata_o |= rd_uart_i.raw;
    if (sel_o[`MINION_REGION_BOARD])
      rdata_o |= rd_board_i;
  end

endmodule
`default_nettype wire

//--- design/minion_pkg.sv
/*
 * shared types: region index and the uart status word
 */
`default_nettype none
`include "minion_settings.svh"

package minion_pkg;

  typedef logic [$clog2(`MINION_NUM_REGIONS)-1:0] region_t;  // addr[23:20]

  // uart status word, msb first as it appears on the bus
  typedef struct packed {
    logic [`MINION_DATA_W-`MINION_RXFIFO_CNT_W-17:0] reserved;  // reads zero
    logic [`MINION_RXFIFO_CNT_W-1:0]                  avail;     // entries in fifo
    logic                                             almost_full;
    logic                                             full;
    logic                                             rd_err;    // pop while empty
    logic                                             wr_err;    // push while full
    logic                                             head_frame_err;
    logic                                             transmitting;
    logic                                             receiving;
    logic                                             not_empty;
    logic [7:0]                                       head_byte;
  } uart_status_fields_t;

  typedef union packed {
    logic [`MINION_DATA_W-1:0] raw;
    uart_status_fields_t       fields;
  } uart_status_u;

endpackage
`default_nettype wire

//--- design/minion_settings.svh
/*
 * constants for the minion peripheral subsystem
 * region map, bus and port widths, uart baud default, rx fifo geometry
 */
`ifndef MINION_SETTINGS_SVH
`define MINION_SETTINGS_SVH

// address map, region index is addr[23:20]
`define MINION_NUM_REGIONS      16
`define MINION_REGION_UART_CTRL 2   // tx byte / baud divisor, write only
`define MINION_REGION_UART_RX   3   // status read, pop on write
`define MINION_REGION_BOARD     7   // leds out, dip switches in

`define MINION_DATA_W           32  // bus word

// uart
`define MINION_BAUD_DEFAULT     87  // divisor after reset
`define MINION_BAUD_W           16

// receive fifo
`define MINION_RXFIFO_DEPTH     16
`define MINION_RXFIFO_CNT_W     12  // width of avail field in status

// board i/o
`define MINION_LED_W            8
`define MINION_DIP_W            16

`endif
